//--- common/nocPkg.sv
// Shared types for the mesh router: flit identifiers, port order and the flit layout
// Imported by every router block that handles flits

package nocPkg;

  `include "nocRouter_defines.svh"

  // Flit kind carried in the top bits of every flit
  typedef enum logic [2:0] {
    HEADER = 3'd1,
    BODY   = 3'd2,
    TAIL   = 3'd3
  } flitIdT;

  // Router port order
  // Also the bit order of every port vector in the design
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_E = 3'd1,
    PORT_W = 3'd2,
    PORT_S = 3'd3,
    PORT_L = 3'd4
  } portIdxT;

  // One flit, id on top
  // Destination is only meaningful in a header
  typedef struct packed {
    flitIdT                           flitId;
    logic [`ADDR_W-1:0]               dstAddr;
    logic [`FLIT_W-`ADDR_W-3-1:0]     payload;
  } flitT;

endpackage

//--- common/nocRouter_defines.svh
// Size macros for the mesh router
// Include wherever flit, address, buffer or port widths are needed

`ifndef NOC_ROUTER_DEFINES_SVH
`define NOC_ROUTER_DEFINES_SVH

// Bits in one flit
`define FLIT_W 16

// Mesh address, x in the low 2 bits, y in the high 2 bits
`define ADDR_W 4

// Flits held by each input buffer
`define FIFO_DEPTH 4

// North, east, west, south and local
`define NUM_PORTS 5

`endif

//--- design/inputPort/flitFifo.sv
// Input buffer of one router port
// Flits written here appear at the head one cycle later and are read without delay

`timescale 1ns/1ps
`include "nocRouter_defines.svh"

module flitFifo (
  input  logic         clk,
  input  logic         rst,
  input  logic         wrEn,
  input  nocPkg::flitT wrData,
  input  logic         rdEn,
  output nocPkg::flitT rdData,
  output logic         full,
  output logic         empty
);
  import nocPkg::*;

  localparam int AddrW = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
  localparam int CntW = $clog2(`FIFO_DEPTH + 1);

  flitT mem [`FIFO_DEPTH];
  logic [AddrW-1:0] wrPtr;
  logic [AddrW-1:0] rdPtr;
  logic [CntW-1:0] count;

  // Storage only, pointers say what is valid
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= wrData;
    end
  end

  // Pointers wrap at the buffer depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= (wrPtr == AddrW'(`FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (rdEn) begin
        rdPtr <= (rdPtr == AddrW'(`FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Occupancy moves only when one side acts alone
      if (wrEn && !rdEn) begin
        count <= count + 1'b1;
      end else if (rdEn && !wrEn) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head of queue straight from the array
  assign rdData = mem[rdPtr];
  assign full = (count == CntW'(`FIFO_DEPTH));
  assign empty = (count == '0);

  // Writer must watch inReady, which is this full flag inverted
  aNoWriteWhenFull : assert property (@(posedge clk) disable iff (rst)
    !(wrEn && full));

  // Pop logic upstream must never read an empty buffer
  aNoReadWhenEmpty : assert property (@(posedge clk) disable iff (rst)
    !(rdEn && empty));

endmodule

//--- design/inputPort/inputPort.sv
// One router input: buffer, route computation and the request toward the output arbiters
// Pops a flit for each cycle it is granted, and drains packets that have no route

`timescale 1ns/1ps
`include "nocRouter_defines.svh"

module inputPort (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,
  input  nocPkg::flitT          inFlit,
  input  logic                  grantIn,
  input  logic [7:0]            rxyInit,
  input  logic [3:0]            cxInit,
  input  logic [`ADDR_W-1:0]    curAddrInit,
  output logic                  inReady,
  output nocPkg::flitT          headFlit,
  output logic [`NUM_PORTS-1:0] portReq
);
  import nocPkg::*;

  logic full;
  logic empty;
  logic wrEn;
  logic pop;
  logic [`NUM_PORTS-1:0] lbdrPorts;
  logic [`NUM_PORTS-1:0] routeReg;
  logic routePending;
  logic routeValid;
  logic routeZero;
  logic reqAny;

  assign inReady = ~full;
  assign wrEn = inValid & ~full;

  flitFifo fifo0 (
    .clk(clk), .rst(rst),
    .wrEn(wrEn), .wrData(inFlit),
    .rdEn(pop), .rdData(headFlit),
    .full(full), .empty(empty)
  );

  lbdrRoute lbdr0 (
    .clk(clk), .rst(rst), .empty(empty),
    .rxyInit(rxyInit), .cxInit(cxInit), .curAddrInit(curAddrInit),
    .headFlit(headFlit), .ports(lbdrPorts)
  );

  // No port at all means the packet is dropped here
  assign routeZero = routeValid & (routeReg == '0);
  // Request only while a flit is actually waiting
  assign reqAny = routeValid & ~routeZero & ~empty;
  assign portReq = reqAny ? routeReg : '0;
  // Drop mode pops on its own, otherwise only on grant
  assign pop = (routeZero & ~empty) | (grantIn & reqAny);

  // Route pending for one cycle while LBDR registers the new header
  // The latched copy survives the buffer running dry mid-packet
  always_ff @(posedge clk) begin
    if (rst) begin
      routePending <= 1'b0;
      routeValid <= 1'b0;
      routeReg <= '0;
    end else begin
      routePending <= !routeValid && !routePending && !empty
                      && (headFlit.flitId == HEADER);
      if (routePending) begin
        routeValid <= 1'b1;
        routeReg <= lbdrPorts;
      end else if (pop && headFlit.flitId == TAIL) begin
        // Packet done, next header must be routed afresh
        routeValid <= 1'b0;
      end
    end
  end

endmodule

//--- design/inputPort/lbdrRoute.sv
// Minimal LBDR route computation for one input port
// Routes the header at the buffer head and keeps that port for the rest of the packet

`timescale 1ns/1ps
`include "nocRouter_defines.svh"

module lbdrRoute (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  empty,
  input  logic [7:0]            rxyInit,
  input  logic [3:0]            cxInit,
  input  logic [`ADDR_W-1:0]    curAddrInit,
  input  nocPkg::flitT          headFlit,
  output logic [`NUM_PORTS-1:0] ports
);
  import nocPkg::*;

  logic [7:0] rxy;
  logic [3:0] cx;
  logic [`ADDR_W-1:0] curAddr;

  logic [1:0] xCur;
  logic [1:0] yCur;
  logic [1:0] xDst;
  logic [1:0] yDst;
  logic goN;
  logic goE;
  logic goW;
  logic goS;
  logic [`NUM_PORTS-1:0] nextPorts;

  // Configuration is sampled while rst is high, then frozen
  always_ff @(posedge clk) begin
    if (rst) begin
      rxy <= rxyInit;
      cx <= cxInit;
      curAddr <= curAddrInit;
    end
  end

  // x in low bits, y in high bits
  assign xCur = curAddr[1:0];
  assign yCur = curAddr[3:2];
  assign xDst = headFlit.dstAddr[1:0];
  assign yDst = headFlit.dstAddr[3:2];

  // Candidate directions, north is toward smaller y
  assign goN = (yDst < yCur);
  assign goE = (xCur < xDst);
  assign goW = (xDst < xCur);
  assign goS = (yCur < yDst);

  // Straight moves always allowed
  // Diagonal quadrants pick a side through the Rxy pair
  // Rxy order ne nw en es wn ws se sw, Cx order n e w s
  always_comb begin
    nextPorts = '0;
    nextPorts[PORT_N] = ((goN & ~goE & ~goW) | (goN & goE & rxy[0])
                        | (goN & goW & rxy[1])) & cx[0];
    nextPorts[PORT_E] = ((goE & ~goN & ~goS) | (goE & goN & rxy[2])
                        | (goE & goS & rxy[3])) & cx[1];
    nextPorts[PORT_W] = ((goW & ~goN & ~goS) | (goW & goN & rxy[4])
                        | (goW & goS & rxy[5])) & cx[2];
    nextPorts[PORT_S] = ((goS & ~goE & ~goW) | (goS & goE & rxy[6])
                        | (goS & goW & rxy[7])) & cx[3];
    // Own address, deliver locally
    nextPorts[PORT_L] = ~goN & ~goE & ~goW & ~goS;
  end

  // Recomputed on headers only
  // Body and tail flits see the held value
  always_ff @(posedge clk) begin
    if (rst || empty) begin
      ports <= '0;
    end else if (headFlit.flitId == HEADER) begin
      ports <= nextPorts;
    end
  end

  // Rxy pairs must not enable both sides of one quadrant
  aPortsOneHot : assert property (@(posedge clk) disable iff (rst)
    $onehot0(ports));

endmodule

//--- design/meshRouter.sv
// Five-port wormhole router for a 4x4 mesh
// Input ports request outputs, arbiters pick a winner, a registered crossbar forwards

`timescale 1ns/1ps
`include "nocRouter_defines.svh"

module meshRouter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [7:0]            rxyInit,
  input  logic [3:0]            cxInit,
  input  logic [`ADDR_W-1:0]    curAddrInit,
  input  logic [`NUM_PORTS-1:0] inValid,
  input  nocPkg::flitT          inFlit [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] inReady,
  output logic [`NUM_PORTS-1:0] outValid,
  output nocPkg::flitT          outFlit [`NUM_PORTS]
);
  import nocPkg::*;

  // Indexed by input, one bit per output
  logic [`NUM_PORTS-1:0] portReq [`NUM_PORTS];
  // Indexed by output, one bit per input
  logic [`NUM_PORTS-1:0] outReq [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] grant [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] grantIn;
  logic [`NUM_PORTS-1:0] xbarValid;
  flitT headFlit [`NUM_PORTS];
  flitT xbarFlit [`NUM_PORTS];
  flitIdT fwdFlitId [`NUM_PORTS];

  for (genvar g = 0; g < `NUM_PORTS; g++) begin : gInPort
    inputPort inPort (
      .clk(clk), .rst(rst),
      .inValid(inValid[g]), .inFlit(inFlit[g]),
      .grantIn(grantIn[g]),
      .rxyInit(rxyInit), .cxInit(cxInit), .curAddrInit(curAddrInit),
      .inReady(inReady[g]), .headFlit(headFlit[g]),
      .portReq(portReq[g])
    );
  end

  for (genvar g = 0; g < `NUM_PORTS; g++) begin : gOutArb
    outArbiter arb (
      .clk(clk), .rst(rst),
      .req(outReq[g]), .fwdFlitId(fwdFlitId[g]),
      .grant(grant[g])
    );
  end

  // Requests turned around from inputs to outputs
  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        outReq[o][i] = portReq[i][o];
      end
    end
  end

  // An input is granted by at most one output, so OR is enough
  always_comb begin
    grantIn = '0;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      grantIn = grantIn | grant[o];
    end
  end

  // Crossbar select from the granted input's head
  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      xbarFlit[o] = '0;
      // Valid only when the owner still has a flit waiting
      xbarValid[o] = |(grant[o] & outReq[o]);
      for (int i = 0; i < `NUM_PORTS; i++) begin
        if (grant[o][i]) begin
          xbarFlit[o] = headFlit[i];
        end
      end
      // Idle cycles look like body flits and keep the lock
      fwdFlitId[o] = xbarValid[o] ? xbarFlit[o].flitId : BODY;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= '0;
    end else begin
      outValid <= xbarValid;
    end
  end

  // Flit data is qualified by outValid
  always_ff @(posedge clk) begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      outFlit[o] <= xbarFlit[o];
    end
  end

endmodule

//--- design/outArbiter.sv
// Round-robin arbiter for one router output
// Holds its grant on one input from the header until that packet's tail has gone through

`timescale 1ns/1ps
`include "nocRouter_defines.svh"

module outArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  nocPkg::flitIdT        fwdFlitId,
  output logic [`NUM_PORTS-1:0] grant
);
  import nocPkg::*;

  localparam int PtrW = $clog2(`NUM_PORTS);

  logic [PtrW-1:0] lastWin;
  logic [PtrW-1:0] nextWin;
  logic [`NUM_PORTS-1:0] nextGrant;
  logic locked;

  // Search starts one past the last winner
  always_comb begin
    int idx;
    logic found;
    nextGrant = '0;
    nextWin = lastWin;
    found = 1'b0;
    for (int k = 1; k <= `NUM_PORTS; k++) begin
      idx = (int'(lastWin) + k) % `NUM_PORTS;
      if (!found && req[idx]) begin
        found = 1'b1;
        nextGrant[idx] = 1'b1;
        nextWin = idx[PtrW-1:0];
      end
    end
  end

  // Lock on grant, release on the forwarded tail
  // One idle cycle follows each release
  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      locked <= 1'b0;
      lastWin <= PtrW'(`NUM_PORTS - 1);
    end else if (locked) begin
      if (fwdFlitId == TAIL) begin
        grant <= '0;
        locked <= 1'b0;
      end
    end else if (|req) begin
      grant <= nextGrant;
      locked <= 1'b1;
      lastWin <= nextWin;
    end
  end

  // Only one packet may own an output
  aGrantOneHot : assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant));

endmodule

//--- nocRouter.f
+incdir+common
common/nocPkg.sv
design/inputPort/flitFifo.sv
design/inputPort/lbdrRoute.sv
design/inputPort/inputPort.sv
design/outArbiter.sv
design/meshRouter.sv
tests/clockGen.sv
tests/routerTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the router testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f nocRouter.f --top-module routerTb -o routerSim

./obj_dir/routerSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  exit 1
fi
exit 0

//--- tests/clockGen.sv
// Testbench clock and reset source, 8 ns period
// Reset is high for 16 cycles at start and again after each restart pulse

`timescale 1ns/1ps

module clockGen (
  input  logic restart,
  output logic clk,
  output logic rst
);

  logic [4:0] cnt;

  initial begin
    clk = 1'b0;
    rst <= 1'b1;
    cnt <= 5'd16;
  end

  always #4 clk = ~clk;

  // Counts reset cycles down, reloads on restart
  always @(posedge clk) begin
    if (restart) begin
      cnt <= 5'd16;
      rst <= 1'b1;
    end else if (cnt != 5'd0) begin
      cnt <= cnt - 5'd1;
      rst <= (cnt != 5'd1);
    end
  end

endmodule

//--- tests/routerTb.sv
// Table-driven testbench for the mesh router
// Sends packets from a table and checks every output flit against per-output expectations

`timescale 1ns/1ps
`include "nocRouter_defines.svh"

module routerTb;
  import nocPkg::*;

  localparam int NumTests = 19;
  localparam int Timeout = 2000;
  localparam logic [3:0] CurAddr = 4'h5;
  // Config sets: vertical-first turns, horizontal-first turns, east link down
  localparam logic [7:0] RxySet [3] = '{8'hC3, 8'h3C, 8'hC3};
  localparam logic [3:0] CxSet [3] = '{4'hF, 4'hF, 4'hD};
  // Columns: kind (0 single, 1 contention, 2 back-pressure), inA, inB, dst, len, cfg
  localparam int Table [NumTests][6] = '{
    '{0, 4, -1, 1, 3, 0}, '{0, 0, -1, 9, 4, 0}, '{0, 1, -1, 4, 2, 0},
    '{0, 2, -1, 6, 3, 0}, '{0, 3, -1, 2, 3, 0}, '{0, 4, -1, 0, 2, 0},
    '{0, 0, -1, 15, 3, 0}, '{0, 1, -1, 8, 4, 0}, '{0, 2, -1, 5, 3, 0},
    '{1, 0, 1, 8, 5, 0}, '{2, 2, 4, 6, 10, 0},
    '{0, 4, -1, 2, 3, 1}, '{0, 0, -1, 0, 2, 1}, '{0, 3, -1, 15, 3, 1},
    '{0, 1, -1, 8, 3, 1}, '{0, 4, -1, 5, 2, 1},
    '{0, 4, -1, 6, 3, 2}, '{0, 4, -1, 1, 4, 2}, '{0, 3, -1, 15, 3, 2}
  };

  logic clk;
  logic rst;
  logic restart;
  logic [7:0] rxyInit;
  logic [3:0] cxInit;
  logic [`ADDR_W-1:0] curAddrInit;
  logic [`NUM_PORTS-1:0] inValid;
  flitT inFlit [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] inReady;
  logic [`NUM_PORTS-1:0] outValid;
  flitT outFlit [`NUM_PORTS];

  // Expected flits, indexed by output * 5 + input
  flitT expQ [25][$];
  int owner [`NUM_PORTS];
  int errors = 0;
  int failedTests = 0;
  bit timedOut = 0;
  bit sawFull [`NUM_PORTS];
  int acceptedAtFull [`NUM_PORTS];

  clockGen clkGen0 (.restart(restart), .clk(clk), .rst(rst));

  meshRouter dut0 (
    .clk(clk), .rst(rst),
    .rxyInit(rxyInit), .cxInit(cxInit), .curAddrInit(curAddrInit),
    .inValid(inValid), .inFlit(inFlit),
    .inReady(inReady), .outValid(outValid), .outFlit(outFlit)
  );

  task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Reference LBDR decision for the fixed router address, -1 means dropped
  function automatic int routeModel(logic [3:0] dst, logic [7:0] rxy, logic [3:0] cx);
    int xc;
    int yc;
    int xd;
    int yd;
    int port;
    xc = int'(CurAddr[1:0]);
    yc = int'(CurAddr[3:2]);
    xd = int'(dst[1:0]);
    yd = int'(dst[3:2]);
    if (xd == xc && yd == yc) begin
      return 4;
    end
    if (xd == xc) begin
      port = (yd < yc) ? 0 : 3;
    end else if (yd == yc) begin
      port = (xd > xc) ? 1 : 2;
    end else if (yd < yc && xd > xc) begin
      port = rxy[0] ? 0 : (rxy[2] ? 1 : -1);
    end else if (yd < yc) begin
      port = rxy[1] ? 0 : (rxy[4] ? 2 : -1);
    end else if (xd > xc) begin
      port = rxy[6] ? 3 : (rxy[3] ? 1 : -1);
    end else begin
      port = rxy[7] ? 3 : (rxy[5] ? 2 : -1);
    end
    // Cx bits share the port index for n, e, w, s
    if (port >= 0 && !cx[port]) begin
      port = -1;
    end
    return port;
  endfunction

  // Reloads configuration through a fresh reset
  task automatic applyConfig(int cfg);
    int waitCnt;
    @(posedge clk);
    #1;
    rxyInit = RxySet[cfg];
    cxInit = CxSet[cfg];
    restart = 1'b1;
    @(posedge clk);
    #1;
    restart = 1'b0;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      owner[o] = -1;
    end
    waitCnt = 0;
    while (rst && !timedOut) begin
      @(posedge clk);
      waitCnt++;
      if (waitCnt > Timeout) begin
        timedOut = 1;
        errors++;
        $display("timeout: reset never released");
      end
    end
  endtask

  task automatic sendPacket(int port, logic [3:0] dst, int len, int outPort);
    flitT flit;
    int waitCnt;
    @(posedge clk);
    #1;
    for (int k = 0; k < len && !timedOut; k++) begin
      flit.flitId = (k == 0) ? HEADER : ((k == len - 1) ? TAIL : BODY);
      flit.dstAddr = dst;
      flit.payload = 9'($urandom);
      inFlit[port] = flit;
      inValid[port] = 1'b1;
      waitCnt = 0;
      // Flit is taken on the next edge once inReady is high
      while (!inReady[port] && !timedOut) begin
        if (!sawFull[port]) begin
          sawFull[port] = 1;
          acceptedAtFull[port] = k;
        end
        @(posedge clk);
        #1;
        waitCnt++;
        if (waitCnt > Timeout) begin
          timedOut = 1;
          errors++;
          $display("timeout: input %0d never became ready", port);
        end
      end
      if (outPort >= 0) begin
        expQ[outPort * 5 + port].push_back(flit);
      end
      @(posedge clk);
      #1;
    end
    inValid[port] = 1'b0;
  endtask

  // Waits until every expected flit has come out
  task automatic drainWait();
    int waitCnt;
    bit busy;
    waitCnt = 0;
    busy = 1;
    while (busy && !timedOut) begin
      busy = 0;
      for (int q = 0; q < 25; q++) begin
        if (expQ[q].size() != 0) begin
          busy = 1;
        end
      end
      if (busy) begin
        @(posedge clk);
        waitCnt++;
        if (waitCnt > Timeout) begin
          timedOut = 1;
          errors++;
          $display("timeout: expected flits never left the router");
        end
      end
    end
  endtask

  // Outputs are registered, so sample them mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      for (int o = 0; o < `NUM_PORTS; o++) begin
        if (outValid[o]) begin
          if (owner[o] < 0) begin
            if (outFlit[o].flitId != HEADER) begin
              errors++;
              $display("output %0d sent a flit outside any packet at %0t", o, $time);
            end else begin
              for (int i = 0; i < `NUM_PORTS; i++) begin
                if (owner[o] < 0 && expQ[o * 5 + i].size() != 0
                    && expQ[o * 5 + i][0] == outFlit[o]) begin
                  owner[o] = i;
                end
              end
              if (owner[o] < 0) begin
                errors++;
                $display("output %0d sent an unexpected header at %0t", o, $time);
              end
            end
          end
          // Flits of the owning packet must follow without interleaving
          if (owner[o] >= 0) begin
            if (expQ[o * 5 + owner[o]].size() == 0) begin
              errors++;
              $display("output %0d sent more flits than the packet had", o);
            end else begin
              checkVal($sformatf("outFlit[%0d]", o), 32'(outFlit[o]),
                       32'(expQ[o * 5 + owner[o]].pop_front()));
            end
            if (outFlit[o].flitId == TAIL) begin
              owner[o] = -1;
            end
          end
        end
      end
    end
  end

  initial begin
    int curCfg;
    int errBefore;
    int outP;
    int kind;
    int inA;
    int inB;
    int len;
    logic [3:0] dst;
    void'($urandom(21));
    restart = 1'b0;
    rxyInit = RxySet[0];
    cxInit = CxSet[0];
    curAddrInit = CurAddr;
    inValid = '0;
    for (int p = 0; p < `NUM_PORTS; p++) begin
      inFlit[p] = '0;
      owner[p] = -1;
      sawFull[p] = 0;
      acceptedAtFull[p] = 0;
    end
    curCfg = 0;
    applyConfig(0);

    // Idle router after reset
    errBefore = errors;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      checkVal("outValid", 32'(outValid), 32'h0);
      checkVal("inReady", 32'(inReady), 32'h1F);
    end
    if (errors != errBefore) begin
      failedTests++;
    end
    $display("test 0 reset state: %s", (errors == errBefore) ? "ok" : "FAILED");

    for (int t = 0; t < NumTests && !timedOut; t++) begin
      kind = Table[t][0];
      inA = Table[t][1];
      inB = Table[t][2];
      dst = 4'(Table[t][3]);
      len = Table[t][4];
      errBefore = errors;
      if (Table[t][5] != curCfg) begin
        curCfg = Table[t][5];
        applyConfig(curCfg);
      end
      outP = routeModel(dst, RxySet[curCfg], CxSet[curCfg]);
      if (kind == 0) begin
        sendPacket(inA, dst, len, outP);
      end else if (kind == 1) begin
        fork
          sendPacket(inA, dst, len, outP);
          sendPacket(inB, dst, len, outP);
        join
      end else begin
        sawFull[inB] = 0;
        fork
          sendPacket(inA, dst, len, outP);
          begin
            repeat (3) @(posedge clk);
            sendPacket(inB, dst, len, outP);
          end
        join
        if (!sawFull[inB]) begin
          errors++;
          $display("input %0d never showed back-pressure", inB);
        end else begin
          checkVal("acceptedBeforeStall", 32'(acceptedAtFull[inB]), 32'(`FIFO_DEPTH));
        end
      end
      drainWait();
      repeat (8) @(posedge clk);
      if (errors != errBefore) begin
        failedTests++;
      end
      $display("test %0d kind %0d in %0d dst %0d to port %0d: %s", t + 1, kind, inA,
               dst, outP, (errors == errBefore) ? "ok" : "FAILED");
    end

    $display("tests %0d, failed %0d, errors %0d", NumTests + 1, failedTests, errors);
    if (errors == 0 && !timedOut) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
